// ==== source/core_isa_pkg.sv ====
// ----------------------------------------------------------------------
// Accumulator core ISA definitions
// Opcode encoding, instruction field positions and the core FSM states
// ----------------------------------------------------------------------

`default_nettype none

package core_isa_pkg;

    // Instruction layout: opcode on top, immediate or byte address below
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int IMM_W   = 16;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LD   = 4'h3,
        OP_ST   = 4'h4,
        OP_ADD  = 4'h5,
        OP_BNZ  = 4'h6,
        OP_HALT = 4'h7
    } opcode_e;

    // Fetch and data phases each take a request and a wait state
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_EXEC,
        ST_DATA,
        ST_DATA_WAIT,
        ST_HALT
    } core_state_e;

endpackage

`default_nettype wire

// ==== source/obi_bus_pkg.sv ====
// ----------------------------------------------------------------------
// OBI bus and address map definitions
// Bus widths, memory geometry and the status peripheral registers
// ----------------------------------------------------------------------

`default_nettype none

package obi_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // 256 words of 32 bits, 1 KiB
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = 8;

    // Everything at or above VP_BASE belongs to the status peripheral
    localparam logic [ADDR_W-1:0] VP_BASE   = 32'h0000_F000;
    localparam logic [ADDR_W-1:0] VP_STDOUT = 32'h0000_F000;
    localparam logic [ADDR_W-1:0] VP_EXIT   = 32'h0000_F004;

endpackage

`default_nettype wire

// ==== source/acc_core.sv ====
// ----------------------------------------------------------------------
// Accumulator core
// Fetches from the boot address over the instruction OBI, runs eight
// opcodes against one accumulator and halts on OP_HALT
// ----------------------------------------------------------------------

`default_nettype none

module acc_core (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             fetch_enable_i,
    input  logic [obi_bus_pkg::ADDR_W-1:0]   boot_addr_i,

    output logic                             instr_req_o,
    input  logic                             instr_gnt_i,
    output logic [obi_bus_pkg::ADDR_W-1:0]   instr_addr_o,
    input  logic                             instr_rvalid_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]   instr_rdata_i,

    output logic                             data_req_o,
    input  logic                             data_gnt_i,
    output logic [obi_bus_pkg::ADDR_W-1:0]   data_addr_o,
    output logic                             data_we_o,
    output logic [obi_bus_pkg::DATA_W-1:0]   data_wdata_o,
    input  logic                             data_rvalid_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]   data_rdata_i,

    output logic                             halted_o
);

    import obi_bus_pkg::*;
    import core_isa_pkg::*;

    core_state_e         state_q;
    logic [ADDR_W-1:0]   pc_q;
    logic [DATA_W-1:0]   acc_q;
    logic [DATA_W-1:0]   ir_q;

    opcode_e             opcode;
    logic [DATA_W-1:0]   imm_data;
    logic [ADDR_W-1:0]   imm_addr;

    assign opcode   = opcode_e'(ir_q[OPC_MSB:OPC_LSB]);
    assign imm_data = {{(DATA_W-IMM_W){1'b0}}, ir_q[IMM_W-1:0]};
    assign imm_addr = {{(ADDR_W-IMM_W){1'b0}}, ir_q[IMM_W-1:0]};

    // ------------------------------------------------------------------
    // Bus outputs, straight from the state
    // ------------------------------------------------------------------
    assign instr_req_o  = (state_q == ST_FETCH);
    assign instr_addr_o = pc_q;

    assign data_req_o   = (state_q == ST_DATA);
    assign data_addr_o  = imm_addr;
    assign data_we_o    = (state_q == ST_DATA) && (opcode == OP_ST);
    assign data_wdata_o = acc_q;

    assign halted_o     = (state_q == ST_HALT);

    // ------------------------------------------------------------------
    // Fetch / execute FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (fetch_enable_i) begin
                        pc_q    <= boot_addr_i;
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (instr_gnt_i) begin
                        state_q <= ST_FETCH_WAIT;
                    end
                end
                ST_FETCH_WAIT: begin
                    if (instr_rvalid_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    // Default path is the next sequential fetch
                    state_q <= ST_FETCH;
                    pc_q    <= pc_q + ADDR_W'(4);
                    case (opcode)
                        OP_LDI:  acc_q <= imm_data;
                        OP_ADDI: acc_q <= acc_q + imm_data;
                        OP_LD, OP_ST, OP_ADD: begin
                            state_q <= ST_DATA;
                        end
                        OP_BNZ: begin
                            if (acc_q != '0) begin
                                pc_q <= imm_addr;
                            end
                        end
                        OP_HALT: state_q <= ST_HALT;
                        default: ;
                    endcase
                end
                ST_DATA: begin
                    if (data_gnt_i) begin
                        state_q <= ST_DATA_WAIT;
                    end
                end
                ST_DATA_WAIT: begin
                    if (data_rvalid_i) begin
                        if (opcode == OP_LD) begin
                            acc_q <= data_rdata_i;
                        end else if (opcode == OP_ADD) begin
                            acc_q <= acc_q + data_rdata_i;
                        end
                        state_q <= ST_FETCH;
                    end
                end
                // Halted for good, only reset leaves
                default: state_q <= ST_HALT;
            endcase
        end
    end

    // Instruction register captures the fetched word
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_FETCH_WAIT) && instr_rvalid_i) begin
            ir_q <= instr_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/dual_port_mem.sv ====
// ----------------------------------------------------------------------
// Dual port word memory
// OBI instruction and data ports with one cycle read latency, plus a
// load port used to fill the array while the core is idle
// ----------------------------------------------------------------------

`default_nettype none

module dual_port_mem (
    input  logic                               clk_i,
    input  logic                               rst_n_i,

    input  logic                               instr_req_i,
    output logic                               instr_gnt_o,
    input  logic [obi_bus_pkg::ADDR_W-1:0]     instr_addr_i,
    output logic                               instr_rvalid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]     instr_rdata_o,

    input  logic                               data_req_i,
    output logic                               data_gnt_o,
    input  logic [obi_bus_pkg::ADDR_W-1:0]     data_addr_i,
    input  logic                               data_we_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]     data_wdata_i,
    output logic                               data_rvalid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]     data_rdata_o,

    input  logic                               load_en_i,
    input  logic [obi_bus_pkg::MEM_IDX_W-1:0]  load_addr_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]     load_data_i
);

    import obi_bus_pkg::*;

    logic [DATA_W-1:0]     mem_q [MEM_WORDS];
    logic [MEM_IDX_W-1:0]  instr_idx;
    logic [MEM_IDX_W-1:0]  data_idx;

    // Word index from byte address bits 9..2
    assign instr_idx = instr_addr_i[MEM_IDX_W+1:2];
    assign data_idx  = data_addr_i[MEM_IDX_W+1:2];

    // Never stalls
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    always_ff @(posedge clk_i) begin
        if (data_req_i && data_we_i) begin
            mem_q[data_idx] <= data_wdata_i;
        end
        if (load_en_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end
        instr_rdata_o <= mem_q[instr_idx];
        data_rdata_o  <= mem_q[data_idx];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/data_bus_demux.sv ====
// ----------------------------------------------------------------------
// Data bus demux
// Steers the core data OBI to memory or to the status peripheral by
// address and returns the response of the granted target
// ----------------------------------------------------------------------

`default_nettype none

module data_bus_demux (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            req_i,
    output logic                            gnt_o,
    input  logic [obi_bus_pkg::ADDR_W-1:0]  addr_i,
    input  logic                            we_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]  wdata_i,
    output logic                            rvalid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]  rdata_o,

    output logic                            mem_req_o,
    input  logic                            mem_gnt_i,
    input  logic                            mem_rvalid_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]  mem_rdata_i,

    output logic                            vp_req_o,
    input  logic                            vp_gnt_i,
    input  logic                            vp_rvalid_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]  vp_rdata_i
);

    import obi_bus_pkg::*;

    logic  sel_vp;
    logic  rsp_vp_q;

    // ------------------------------------------------------------------
    // Request path, decoded in the request cycle
    // ------------------------------------------------------------------
    assign sel_vp    = (addr_i >= VP_BASE);
    assign mem_req_o = req_i && !sel_vp;
    assign vp_req_o  = req_i && sel_vp;
    assign gnt_o     = sel_vp ? vp_gnt_i : mem_gnt_i;

    // Remember which target took the transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_vp_q <= 1'b0;
        end else if (req_i && gnt_o) begin
            rsp_vp_q <= sel_vp;
        end
    end

    // ------------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------------
    assign rvalid_o = rsp_vp_q ? vp_rvalid_i : mem_rvalid_i;
    assign rdata_o  = rsp_vp_q ? vp_rdata_i : mem_rdata_i;

endmodule

`default_nettype wire

// ==== source/vp_status.sv ====
// ----------------------------------------------------------------------
// Status virtual peripheral
// Stdout register gives a one cycle output pulse, exit register ends
// the run and holds the exit value
// ----------------------------------------------------------------------

`default_nettype none

module vp_status (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            req_i,
    output logic                            gnt_o,
    input  logic [obi_bus_pkg::ADDR_W-1:0]  addr_i,
    input  logic                            we_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]  wdata_i,
    output logic                            rvalid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]  rdata_o,

    output logic                            out_valid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]  out_data_o,
    output logic                            exit_valid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]  exit_value_o
);

    import obi_bus_pkg::*;

    logic  wr_stdout;
    logic  wr_exit;

    assign wr_stdout = req_i && we_i && (addr_i == VP_STDOUT);
    assign wr_exit   = req_i && we_i && (addr_i == VP_EXIT);

    assign gnt_o   = req_i;
    // Registers are write only
    assign rdata_o = '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_o     <= 1'b0;
            out_valid_o  <= 1'b0;
            exit_valid_o <= 1'b0;
        end else begin
            rvalid_o    <= req_i;
            out_valid_o <= wr_stdout;
            if (wr_exit) begin
                exit_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_stdout) begin
            out_data_o <= wdata_i;
        end
        if (wr_exit) begin
            exit_value_o <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/core_dut_wrap.sv ====
// ----------------------------------------------------------------------
// Core test subsystem top level
// Accumulator core, dual port memory and status peripheral, with the
// core data bus split between memory and peripheral
// ----------------------------------------------------------------------

`default_nettype none

module core_dut_wrap (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               fetch_enable_i,
    input  logic [obi_bus_pkg::ADDR_W-1:0]     boot_addr_i,

    input  logic                               load_en_i,
    input  logic [obi_bus_pkg::MEM_IDX_W-1:0]  load_addr_i,
    input  logic [obi_bus_pkg::DATA_W-1:0]     load_data_i,

    output logic                               halted_o,
    output logic                               out_valid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]     out_data_o,
    output logic                               exit_valid_o,
    output logic [obi_bus_pkg::DATA_W-1:0]     exit_value_o
);

    import obi_bus_pkg::*;

    // Instruction OBI, core to memory
    logic               instr_req;
    logic               instr_gnt;
    logic [ADDR_W-1:0]  instr_addr;
    logic               instr_rvalid;
    logic [DATA_W-1:0]  instr_rdata;

    // Data OBI, core side of the demux
    logic               data_req;
    logic               data_gnt;
    logic [ADDR_W-1:0]  data_addr;
    logic               data_we;
    logic [DATA_W-1:0]  data_wdata;
    logic               data_rvalid;
    logic [DATA_W-1:0]  data_rdata;

    // Target sides
    logic               mem_req;
    logic               mem_gnt;
    logic               mem_rvalid;
    logic [DATA_W-1:0]  mem_rdata;
    logic               vp_req;
    logic               vp_gnt;
    logic               vp_rvalid;
    logic [DATA_W-1:0]  vp_rdata;

    // ------------------------------------------------------------------
    // Core
    // ------------------------------------------------------------------
    acc_core core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req      ),
        .instr_gnt_i    ( instr_gnt      ),
        .instr_addr_o   ( instr_addr     ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_gnt_i     ( data_gnt       ),
        .data_addr_o    ( data_addr      ),
        .data_we_o      ( data_we        ),
        .data_wdata_o   ( data_wdata     ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     ),
        .halted_o       ( halted_o       )
    );

    // ------------------------------------------------------------------
    // Data bus split
    // ------------------------------------------------------------------
    data_bus_demux demux_i (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .req_i        ( data_req    ),
        .gnt_o        ( data_gnt    ),
        .addr_i       ( data_addr   ),
        .we_i         ( data_we     ),
        .wdata_i      ( data_wdata  ),
        .rvalid_o     ( data_rvalid ),
        .rdata_o      ( data_rdata  ),
        .mem_req_o    ( mem_req     ),
        .mem_gnt_i    ( mem_gnt     ),
        .mem_rvalid_i ( mem_rvalid  ),
        .mem_rdata_i  ( mem_rdata   ),
        .vp_req_o     ( vp_req      ),
        .vp_gnt_i     ( vp_gnt      ),
        .vp_rvalid_i  ( vp_rvalid   ),
        .vp_rdata_i   ( vp_rdata    )
    );

    // ------------------------------------------------------------------
    // Memory and status peripheral share addr, we and wdata
    // ------------------------------------------------------------------
    dual_port_mem mem_i (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .instr_req_i    ( instr_req    ),
        .instr_gnt_o    ( instr_gnt    ),
        .instr_addr_i   ( instr_addr   ),
        .instr_rvalid_o ( instr_rvalid ),
        .instr_rdata_o  ( instr_rdata  ),
        .data_req_i     ( mem_req      ),
        .data_gnt_o     ( mem_gnt      ),
        .data_addr_i    ( data_addr    ),
        .data_we_i      ( data_we      ),
        .data_wdata_i   ( data_wdata   ),
        .data_rvalid_o  ( mem_rvalid   ),
        .data_rdata_o   ( mem_rdata    ),
        .load_en_i      ( load_en_i    ),
        .load_addr_i    ( load_addr_i  ),
        .load_data_i    ( load_data_i  )
    );

    vp_status vp_status_i (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .req_i        ( vp_req       ),
        .gnt_o        ( vp_gnt       ),
        .addr_i       ( data_addr    ),
        .we_i         ( data_we      ),
        .wdata_i      ( data_wdata   ),
        .rvalid_o     ( vp_rvalid    ),
        .rdata_o      ( vp_rdata     ),
        .out_valid_o  ( out_valid_o  ),
        .out_data_o   ( out_data_o   ),
        .exit_valid_o ( exit_valid_o ),
        .exit_value_o ( exit_value_o )
    );

endmodule

`default_nettype wire

// ==== dv/tb_core_dut_wrap.sv ====
// ----------------------------------------------------------------------
// Testbench for the core test subsystem
// Loads small programs over the load port, runs them on the core and
// checks stdout, exit and halt against an ISA reference model
// ----------------------------------------------------------------------

`default_nettype none

module tb_core_dut_wrap;

    import core_isa_pkg::*;
    import obi_bus_pkg::*;

    // Five 256 word loads and under a hundred instructions at up to
    // 5 cycles each fit in about 2000 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MODEL_STEPS    = 4000;
    localparam logic [15:0] STDOUT_IMM = VP_STDOUT[15:0];
    localparam logic [15:0] EXIT_IMM   = VP_EXIT[15:0];

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  fetch_enable;
    logic [ADDR_W-1:0]     boot_addr;
    logic                  load_en;
    logic [MEM_IDX_W-1:0]  load_addr;
    logic [DATA_W-1:0]     load_data;
    logic                  halted;
    logic                  out_valid;
    logic [DATA_W-1:0]     out_data;
    logic                  exit_valid;
    logic [DATA_W-1:0]     exit_value;

    // Memory image of the current test and the model results
    logic [DATA_W-1:0]     prog_mem [MEM_WORDS];
    logic [DATA_W-1:0]     exp_out [$];
    bit                    exp_exit_valid;
    logic [DATA_W-1:0]     exp_exit;
    int                    got_count = 0;
    int                    cycle_count = 0;
    int                    wp;
    logic [31:0]           lcg_state = 32'd53019;

    core_dut_wrap dut (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .boot_addr_i    ( boot_addr    ),
        .load_en_i      ( load_en      ),
        .load_addr_i    ( load_addr    ),
        .load_data_i    ( load_data    ),
        .halted_o       ( halted       ),
        .out_valid_o    ( out_valid    ),
        .out_data_o     ( out_data     ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------
    // Reporting and checking
    // ------------------------------------------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR at time %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, the run did not finish in %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    // Stdout pulses last one cycle, so look at every falling edge
    always @(negedge clk) begin
        if (out_valid) begin
            if (got_count >= exp_out.size()) begin
                stop_with_failure("out_valid_o pulsed more often than the model expects");
            end else begin
                check_value("out_data_o", out_data, exp_out[got_count]);
                got_count++;
            end
        end
    end

    // ------------------------------------------------------------------
    // ISA reference model
    // ------------------------------------------------------------------
    function automatic bit run_model(input logic [31:0] boot);
        logic [31:0] mem [MEM_WORDS];
        logic [31:0] pc;
        logic [31:0] acc;
        logic [31:0] ir;
        logic [31:0] addr;
        logic [31:0] rd;
        bit          stop;
        int          i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i[7:0]] = prog_mem[i[7:0]];
        end
        exp_out.delete();
        exp_exit_valid = 1'b0;
        exp_exit = 32'h0;
        pc = boot;
        acc = 32'h0;
        stop = 1'b0;
        for (i = 0; i < MODEL_STEPS && !stop; i++) begin
            ir = mem[pc[9:2]];
            addr = {16'h0, ir[15:0]};
            pc = pc + 32'd4;
            // Peripheral reads return zero
            rd = (addr >= VP_BASE) ? 32'h0 : mem[addr[9:2]];
            case (opcode_e'(ir[31:28]))
                OP_LDI:  acc = addr;
                OP_ADDI: acc = acc + addr;
                OP_LD:   acc = rd;
                OP_ADD:  acc = acc + rd;
                OP_ST: begin
                    if (addr == VP_STDOUT) begin
                        exp_out.push_back(acc);
                    end else if (addr == VP_EXIT) begin
                        exp_exit_valid = 1'b1;
                        exp_exit = acc;
                    end else if (addr < VP_BASE) begin
                        mem[addr[9:2]] = acc;
                    end
                end
                OP_BNZ: begin
                    if (acc != 32'h0) begin
                        pc = addr;
                    end
                end
                OP_HALT: stop = 1'b1;
                default: ;
            endcase
        end
        return stop;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] encode_instr(input opcode_e op, input logic [15:0] imm);
        return {op, 12'h000, imm};
    endfunction

    // ------------------------------------------------------------------
    // Program building and DUT control
    // ------------------------------------------------------------------
    // Unused words hold HALT with their own index as immediate
    task automatic start_program(input int first_word);
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i[7:0]] = encode_instr(OP_HALT, 16'(i));
        end
        wp = first_word;
    endtask

    task automatic emit(input opcode_e op, input logic [15:0] imm);
        prog_mem[wp[7:0]] = encode_instr(op, imm);
        wp++;
    endtask

    task automatic set_word(input int idx, input logic [31:0] value);
        prog_mem[idx[7:0]] = value;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        fetch_enable = 1'b0;
        load_en = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic load_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            #1;
            load_en = 1'b1;
            load_addr = i[7:0];
            load_data = prog_mem[i[7:0]];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic run_program(input logic [ADDR_W-1:0] boot);
        bit exp_halt;
        apply_reset();
        load_memory();
        exp_halt = run_model(boot);
        got_count = 0;
        boot_addr = boot;
        fetch_enable = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check_value("halted_o", 32'(halted), 32'(exp_halt));
        if (got_count != exp_out.size()) begin
            stop_with_failure($sformatf("Core halted after %0d stdout pulses, %0d expected",
                                        got_count, exp_out.size()));
        end
        check_value("exit_valid_o", 32'(exit_valid), 32'(exp_exit_valid));
        if (exp_exit_valid) begin
            check_value("exit_value_o", exit_value, exp_exit);
        end
        @(posedge clk);
        #1;
        fetch_enable = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_after_reset();
        apply_reset();
        repeat (10) begin
            @(negedge clk);
            check_value("halted_o", 32'(halted), 32'h0);
            check_value("out_valid_o", 32'(out_valid), 32'h0);
            check_value("exit_valid_o", 32'(exit_valid), 32'h0);
        end
    endtask

    task automatic test_immediates();
        start_program(0);
        emit(OP_LDI, 16'h0005);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_ADDI, 16'h0010);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_LDI, 16'hBEEF);
        emit(OP_ADDI, 16'h1111);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_HALT, 16'h0000);
        run_program(32'h0);
    endtask

    task automatic test_memory_round_trip();
        start_program(0);
        emit(OP_LDI, 16'h1234);
        emit(OP_ST, 16'h0200);
        emit(OP_LDI, 16'h0F0F);
        emit(OP_ST, 16'h0204);
        emit(OP_LD, 16'h0200);
        emit(OP_ADD, 16'h0204);
        emit(OP_ADD, 16'h0200);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_ST, EXIT_IMM);
        emit(OP_LD, 16'h0204);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_HALT, 16'h0000);
        run_program(32'h0);
    endtask

    // Counts down from 6 by adding an all ones word
    task automatic test_loop();
        start_program(0);
        set_word(64, 32'hFFFF_FFFF);
        emit(OP_LDI, 16'h0006);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_ADD, 16'h0100);
        emit(OP_BNZ, 16'h0004);
        emit(OP_ST, EXIT_IMM);
        emit(OP_HALT, 16'h0000);
        run_program(32'h0);
    endtask

    task automatic test_boot_address();
        start_program(32);
        emit(OP_LDI, 16'h00A5);
        emit(OP_ST, STDOUT_IMM);
        emit(OP_ADDI, 16'h0001);
        emit(OP_ST, EXIT_IMM);
        emit(OP_HALT, 16'h0000);
        run_program(32'h0000_0080);
    endtask

    task automatic test_random_program();
        logic [31:0] r;
        logic [15:0] daddr;
        int          sel;
        int          n;
        start_program(0);
        for (n = 0; n < 40; n++) begin
            r = lcg_next();
            sel = int'(r[31:16]) % 5;
            // Data words 128 to 255, clear of the program
            daddr = {7'b0000001, r[6:0], 2'b00};
            case (sel)
                0: emit(OP_LDI, r[23:8]);
                1: emit(OP_ADDI, r[23:8]);
                2: emit(OP_ST, daddr);
                3: emit(OP_ADD, daddr);
                default: emit(OP_ST, STDOUT_IMM);
            endcase
        end
        emit(OP_ST, EXIT_IMM);
        emit(OP_HALT, 16'h0000);
        run_program(32'h0);
    endtask

    initial begin
        rst_n = 1'b0;
        fetch_enable = 1'b0;
        boot_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_after_reset();
        test_immediates();
        test_memory_round_trip();
        test_loop();
        test_boot_address();
        test_random_program();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/core_isa_pkg.sv
source/obi_bus_pkg.sv
source/acc_core.sv
source/dual_port_mem.sv
source/data_bus_demux.sv
source/vp_status.sv
source/core_dut_wrap.sv
dv/tb_core_dut_wrap.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator and run it
# The simulator exit status gives pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_core_dut_wrap -o sim_tb

./obj_dir/sim_tb
